// ==== verilog.f ====
+incdir+.
mrs_pkg.sv
mrs_txn_if.sv
mrs_issuer.sv
mrs_outstanding_queue.sv
mrs_responder.sv
memory_read_stage.sv
tb_memory_read_stage.sv

// ==== Makefile ====
# Verilator build and run for the memory read stage testbench

VERILATOR ?= verilator
TOP       ?= tb_memory_read_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_mrs_tasks.svh ====
// Directed test tasks for the memory read stage testbench
// Included inside the testbench top module

`ifndef TB_MRS_TASKS_SVH
`define TB_MRS_TASKS_SVH

// Present one transaction, valid stays high if not accepted within the limit
task automatic present_txn(input logic walk, input tag_t tag, input addr_t addr,
                           input int limit, output bit accepted);
    int waited;
    waited     = 0;
    accepted   = 1'b0;
    in_valid_i = 1'b1;
    in_walk_i  = walk;
    in_tag_i   = tag;
    in_addr_i  = addr;
    while (!accepted && waited < limit) begin
        @(negedge clk_i);
        accepted = in_ready_o;
        @(posedge clk_i);
        #(DRIVE_DLY);
        waited = waited + 1;
    end
    if (accepted) begin
        in_valid_i = 1'b0;
    end
endtask

task automatic send_txn(input logic walk, input tag_t tag, input addr_t addr);
    bit ok;
    present_txn(walk, tag, addr, WAIT_LIMIT, ok);
    if (!ok) begin
        errors     = errors + 1;
        in_valid_i = 1'b0;
        $display("Timeout at time %0t: transaction %h was not accepted", $time, tag);
    end
endtask

// Until every accepted transaction has left the output
task automatic wait_drain();
    int waited;
    bit idle;
    waited = 0;
    idle   = 1'b0;
    while (!idle && waited < WAIT_LIMIT) begin
        @(negedge clk_i);
        idle = (exp_tag_q.size() == 0) && !out_valid_o;
        @(posedge clk_i);
        #(DRIVE_DLY);
        waited = waited + 1;
    end
    if (!idle) begin
        errors = errors + 1;
        $display("Timeout at time %0t: %0d results never came out", $time, exp_tag_q.size());
    end
endtask

// Knob changes land mid-cycle so the drivers see them on the next edge
task automatic set_ready_mode(input int mode);
    @(negedge clk_i);
    ready_mode = mode;
    @(posedge clk_i);
    #(DRIVE_DLY);
endtask

task automatic set_gnt_delay(input int min_cycles, input int max_cycles);
    @(negedge clk_i);
    gnt_min = min_cycles;
    gnt_max = max_cycles;
    @(posedge clk_i);
    #(DRIVE_DLY);
endtask

task automatic check_idle_after_reset();
    repeat (8) begin
        @(negedge clk_i);
        if (mem_req_o !== 1'b0) begin
            errors = errors + 1;
            $display("** Error at time %0t: mem_req_o = %b, expected 0", $time, mem_req_o);
        end
        if (out_valid_o !== 1'b0) begin
            errors = errors + 1;
            $display("** Error at time %0t: out_valid_o = %b, expected 0", $time, out_valid_o);
        end
        @(posedge clk_i);
        #(DRIVE_DLY);
    end
endtask

task automatic run_passthrough();
    int req_before;
    int i;
    req_before = req_cycles;
    for (i = 0; i < 6; i++) begin
        send_txn(1'b0, tag_t'(i), addr_t'($urandom));
    end
    wait_drain();
    if (req_cycles != req_before) begin
        errors = errors + 1;
        $display("Memory request raised for non-walking transactions");
    end
endtask

task automatic run_walking();
    int req_before;
    int i;
    // Delayed grant stretches each request over several cycles
    set_gnt_delay(2, 3);
    req_before = req_cycles;
    for (i = 0; i < 4; i++) begin
        send_txn(1'b1, tag_t'(i + 6), addr_t'($urandom));
    end
    wait_drain();
    if (req_cycles - req_before < 10) begin
        errors = errors + 1;
        $display("Delayed grants did not hold the memory requests");
    end
    // Grant held high, back-to-back walks
    set_gnt_delay(0, 0);
    req_before = req_cycles;
    for (i = 0; i < 4; i++) begin
        send_txn(1'b1, tag_t'(i + 10), addr_t'($urandom));
    end
    wait_drain();
    if (req_cycles - req_before < 4) begin
        errors = errors + 1;
        $display("Walking transactions raised too few memory requests");
    end
    set_gnt_delay(0, 3);
endtask

task automatic run_mixed();
    int i;
    set_ready_mode(READY_RANDOM);
    for (i = 0; i < 40; i++) begin
        send_txn(1'($urandom_range(1, 0)), tag_t'(i), addr_t'($urandom));
        // Occasional idle gap on the input
        repeat ($urandom_range(2, 0)) begin
            @(posedge clk_i);
            #(DRIVE_DLY);
        end
    end
    wait_drain();
    set_ready_mode(READY_HIGH);
endtask

task automatic run_backpressure();
    int  sent;
    int  start_results;
    int  expected;
    bit  ok;
    set_ready_mode(READY_LOW);
    start_results = results;
    sent = 0;
    ok   = 1'b1;
    // Keep presenting until the input stays blocked
    while (ok && sent < `MRS_TXN_DEPTH + 2) begin
        present_txn(1'(sent % 2), tag_t'(sent + 8), addr_t'($urandom), 12, ok);
        if (ok) begin
            sent = sent + 1;
        end
    end
    if (sent != `MRS_TXN_DEPTH) begin
        errors = errors + 1;
        $display("** Error at time %0t: accepted = %0d, expected %0d",
                 $time, sent, `MRS_TXN_DEPTH);
    end
    expected = sent;
    // Release the output, the blocked transaction must get in
    set_ready_mode(READY_HIGH);
    if (!ok) begin
        present_txn(in_walk_i, in_tag_i, in_addr_i, WAIT_LIMIT, ok);
        if (ok) begin
            expected = expected + 1;
        end else begin
            errors     = errors + 1;
            in_valid_i = 1'b0;
            $display("Acceptance did not resume after the output was released");
        end
    end
    wait_drain();
    if (results - start_results != expected) begin
        errors = errors + 1;
        $display("** Error at time %0t: results = %0d, expected %0d",
                 $time, results - start_results, expected);
    end
endtask

`endif

// ==== tb_memory_read_stage.sv ====
// Testbench top for the memory read stage
// Clock, reset, DUT, memory model, result checker and closing report

`default_nettype none

`include "mrs_consts.svh"

module tb_memory_read_stage;

    import mrs_pkg::*;

    localparam int    CLK_HALF     = 20;
    localparam int    DRIVE_DLY    = 2;
    localparam int    WAIT_LIMIT   = 300;
    localparam int    RUN_LIMIT    = 40 * 20000;
    localparam int    SEED         = 90;
    localparam data_t RDATA_XOR    = 32'h5a3c_96e1;
    localparam int    READY_HIGH   = 0;
    localparam int    READY_RANDOM = 1;
    localparam int    READY_LOW    = 2;

    logic  clk_i;
    logic  rst_ni;
    logic  in_valid_i;
    logic  in_ready_o;
    logic  in_walk_i;
    tag_t  in_tag_i;
    addr_t in_addr_i;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_gnt_i;
    logic  mem_rvalid_i;
    data_t mem_rdata_i;
    logic  out_valid_o;
    logic  out_ready_i;
    tag_t  out_tag_o;
    data_t out_data_o;

    // Knobs changed by the tests
    int gnt_min    = 0;
    int gnt_max    = 3;
    int ready_mode = READY_HIGH;

    // Memory model state
    int    gnt_wait = 0;
    int    cyc      = 0;
    int    last_due = 0;
    data_t rsp_data_q[$];
    int    rsp_due_q[$];

    // Expected results in acceptance order, plus counters
    tag_t  exp_tag_q[$];
    data_t exp_data_q[$];
    int    errors     = 0;
    int    checks     = 0;
    int    results    = 0;
    int    req_cycles = 0;

    memory_read_stage DUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_walk_i    (in_walk_i),
        .in_tag_i     (in_tag_i),
        .in_addr_i    (in_addr_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_tag_o    (out_tag_o),
        .out_data_o   (out_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model and output back-pressure
    ////////////////////////////////////////////////////////////////////////////

    // Grant after a random number of request cycles, answer in grant order
    always begin : memory_model
        logic  granted;
        logic  waiting;
        addr_t gnt_addr;
        int    due;
        @(negedge clk_i);
        granted  = rst_ni && mem_req_o && mem_gnt_i;
        waiting  = rst_ni && mem_req_o && !mem_gnt_i;
        gnt_addr = mem_addr_o;
        @(posedge clk_i);
        #(DRIVE_DLY);
        cyc = cyc + 1;
        if (granted) begin
            // rvalid 1 to 3 cycles after the grant, never two in one cycle
            due = cyc + int'($urandom_range(2, 0));
            if (due <= last_due) begin
                due = last_due + 1;
            end
            rsp_data_q.push_back(gnt_addr ^ RDATA_XOR);
            rsp_due_q.push_back(due);
            last_due = due;
            gnt_wait = int'($urandom_range(gnt_max, gnt_min));
        end else if (waiting && gnt_wait > 0) begin
            gnt_wait = gnt_wait - 1;
        end
        mem_gnt_i = (gnt_wait == 0);
        if (rsp_due_q.size() > 0 && rsp_due_q[0] == cyc) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end else begin
            mem_rvalid_i = 1'b0;
        end
    end

    always begin : ready_driver
        @(posedge clk_i);
        #(DRIVE_DLY);
        case (ready_mode)
            READY_RANDOM: out_ready_i = ($urandom_range(3, 0) != 0);
            READY_LOW:    out_ready_i = 1'b0;
            default:      out_ready_i = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checker, sampled mid-cycle where all signals are settled
    ////////////////////////////////////////////////////////////////////////////

    always begin : result_checker
        tag_t  exp_tag;
        data_t exp_data;
        @(negedge clk_i);
        if (rst_ni) begin
            if (in_valid_i && in_ready_o) begin
                exp_tag_q.push_back(in_tag_i);
                exp_data_q.push_back(in_walk_i ? (in_addr_i ^ RDATA_XOR) : in_addr_i);
            end
            // A request belongs to the presented walking transaction
            if (mem_req_o) begin
                req_cycles = req_cycles + 1;
                if (!(in_valid_i && in_walk_i) || mem_addr_o !== in_addr_i) begin
                    errors = errors + 1;
                    $display("Memory request at time %0t without a matching walking input",
                             $time);
                end
            end
            if (out_valid_o && out_ready_i) begin
                results = results + 1;
                if (exp_tag_q.size() == 0) begin
                    errors = errors + 1;
                    $display("Result at time %0t arrived with nothing outstanding", $time);
                end else begin
                    exp_tag  = exp_tag_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    checks   = checks + 1;
                    if (out_tag_o !== exp_tag) begin
                        errors = errors + 1;
                        $display("** Error at time %0t: out_tag_o = %h, expected %h",
                                 $time, out_tag_o, exp_tag);
                    end
                    if (out_data_o !== exp_data) begin
                        errors = errors + 1;
                        $display("** Error at time %0t: out_data_o = %h, expected %h",
                                 $time, out_data_o, exp_data);
                    end
                end
            end
        end
    end

    `include "tb_mrs_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence and closing report
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        void'($urandom(SEED));
        rst_ni       = 1'b0;
        in_valid_i   = 1'b0;
        in_walk_i    = 1'b0;
        in_tag_i     = '0;
        in_addr_i    = '0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        out_ready_i  = 1'b0;
        repeat (5) @(posedge clk_i);
        #(DRIVE_DLY);
        rst_ni = 1'b1;
        check_idle_after_reset();
        run_passthrough();
        run_walking();
        run_mixed();
        run_backpressure();
        $display("Results: %0d, checks: %0d, errors: %0d", results, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Whole-run limit in case a test stalls
    initial begin : watchdog
        #(RUN_LIMIT);
        $display("Run time limit reached, results: %0d, errors: %0d", results, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memory_read_stage.sv ====
// Top level of the page-table walker memory read stage
// Issuer, outstanding queue and responder joined by two queue links

`default_nettype none

module memory_read_stage (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,

    // Input transactions
    input  wire logic           in_valid_i,
    output logic                in_ready_o,
    input  wire logic           in_walk_i,
    input  wire mrs_pkg::tag_t   in_tag_i,
    input  wire mrs_pkg::addr_t  in_addr_i,

    // SRAM-style read port
    output logic                mem_req_o,
    output mrs_pkg::addr_t      mem_addr_o,
    input  wire logic           mem_gnt_i,
    input  wire logic           mem_rvalid_i,
    input  wire mrs_pkg::data_t  mem_rdata_i,

    // Results in acceptance order
    output logic                out_valid_o,
    input  wire logic           out_ready_i,
    output mrs_pkg::tag_t       out_tag_o,
    output mrs_pkg::data_t      out_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////////////////////

    // Issuer to queue, and queue head to responder
    mrs_txn_if enq_if ();
    mrs_txn_if deq_if ();

    // Output handshake done, frees one in-flight slot
    logic retire;

    ////////////////////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////////////////////

    mrs_issuer u_issuer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_walk_i  (in_walk_i),
        .in_tag_i   (in_tag_i),
        .in_addr_i  (in_addr_i),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_gnt_i  (mem_gnt_i),
        .retire_i   (retire),
        .enq_if     (enq_if.writer)
    );

    mrs_outstanding_queue u_outstanding_queue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .enq_if (enq_if.fill),
        .deq_if (deq_if.drain)
    );

    mrs_responder u_responder (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_tag_o    (out_tag_o),
        .out_data_o   (out_data_o),
        .retire_o     (retire),
        .deq_if       (deq_if.reader)
    );

endmodule

`default_nettype wire

// ==== mrs_responder.sv ====
// Read-data capture queue, head pairing and output result register
// Produces the retire pulse on every completed output handshake

`default_nettype none

`include "mrs_consts.svh"

module mrs_responder (
    input  wire logic           clk_i,
    input  wire logic           rst_ni,
    // Memory response side
    input  wire logic           mem_rvalid_i,
    input  wire mrs_pkg::data_t  mem_rdata_i,
    // Output stage
    output logic                out_valid_o,
    input  wire logic           out_ready_i,
    output mrs_pkg::tag_t       out_tag_o,
    output mrs_pkg::data_t      out_data_o,
    // One pulse per delivered result
    output logic                retire_o,
    // Pop side of the outstanding queue
    mrs_txn_if.reader           deq_if
);

    import mrs_pkg::*;

    localparam int PTR_W = $clog2(`MRS_TXN_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MRS_TXN_DEPTH - 1);

    // Read-data queue
    data_t            rd_mem [`MRS_TXN_DEPTH];
    logic [PTR_W-1:0] rd_wptr_q;
    logic [PTR_W-1:0] rd_rptr_q;
    occ_t             rd_cnt_q;
    logic             rd_push;
    logic             rd_pop;
    logic             rd_full;

    // Pairing and output register
    logic       head_ready;
    logic       can_load;
    logic       load;
    out_state_e out_state_q;
    tag_t       out_tag_q;
    data_t      out_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Read-data queue
    ////////////////////////////////////////////////////////////////////////////

    // Responses come in grant order, one per walking transaction
    assign rd_push = mem_rvalid_i;
    assign rd_full = (rd_cnt_q == occ_t'(`MRS_TXN_DEPTH));

    always_ff @(posedge clk_i) begin
        if (rd_push) begin
            rd_mem[rd_wptr_q] <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_wptr_q <= '0;
            rd_rptr_q <= '0;
            rd_cnt_q  <= '0;
        end else begin
            if (rd_push) begin
                rd_wptr_q <= (rd_wptr_q == PTR_LAST) ? '0 : rd_wptr_q + 1'b1;
            end
            if (rd_pop) begin
                rd_rptr_q <= (rd_rptr_q == PTR_LAST) ? '0 : rd_rptr_q + 1'b1;
            end
            if (rd_push && !rd_pop) begin
                rd_cnt_q <= rd_cnt_q + occ_t'(1);
            end else if (!rd_push && rd_pop) begin
                rd_cnt_q <= rd_cnt_q - occ_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Head pairing
    ////////////////////////////////////////////////////////////////////////////

    // A walking head waits for captured read data, others go at once
    assign head_ready = !deq_if.stall && (!deq_if.walk || (rd_cnt_q != '0));
    // Register is free or drains in this cycle
    assign can_load   = (out_state_q == OUT_EMPTY) || out_ready_i;
    assign load       = head_ready && can_load;

    assign deq_if.strobe = load;
    assign rd_pop        = load && deq_if.walk;

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_tag_q  <= deq_if.tag;
            // Pass-through heads carry their address as result data
            out_data_q <= deq_if.walk ? rd_mem[rd_rptr_q] : deq_if.addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            out_state_q <= OUT_EMPTY;
        end else if (load) begin
            out_state_q <= OUT_FULL;
        end else if (out_ready_i) begin
            out_state_q <= OUT_EMPTY;
        end
    end

    assign out_valid_o = (out_state_q == OUT_FULL);
    assign out_tag_o   = out_tag_q;
    assign out_data_o  = out_data_q;
    assign retire_o    = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////

    // Issuer occupancy limit bounds the number of pending responses
    a_rdata_room : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> !rd_full)
        else $error("read data arrived with the read-data queue full");

    a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_tag_o) && $stable(out_data_o))
        else $error("output result changed under back-pressure");

endmodule

`default_nettype wire

// ==== mrs_outstanding_queue.sv ====
// In-order queue of accepted transactions waiting for their result
// Circular buffer with pointers and an entry count

`default_nettype none

`include "mrs_consts.svh"

module mrs_outstanding_queue (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    // Push side from the issuer
    mrs_txn_if.fill    enq_if,
    // Pop side to the responder
    mrs_txn_if.drain   deq_if
);

    import mrs_pkg::*;

    localparam int PTR_W = $clog2(`MRS_TXN_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MRS_TXN_DEPTH - 1);

    // Entry storage
    logic  walk_mem [`MRS_TXN_DEPTH];
    tag_t  tag_mem  [`MRS_TXN_DEPTH];
    addr_t addr_mem [`MRS_TXN_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    occ_t             count_q;
    logic             push;
    logic             pop;

    assign push = enq_if.strobe;
    assign pop  = deq_if.strobe;

    // Status flags
    assign enq_if.stall = (count_q == occ_t'(`MRS_TXN_DEPTH));
    assign deq_if.stall = (count_q == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (push) begin
            walk_mem[wr_ptr_q] <= enq_if.walk;
            tag_mem[wr_ptr_q]  <= enq_if.tag;
            addr_mem[wr_ptr_q] <= enq_if.addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count only moves on an unpaired push or pop
            if (push && !pop) begin
                count_q <= count_q + occ_t'(1);
            end else if (!push && pop) begin
                count_q <= count_q - occ_t'(1);
            end
        end
    end

    // Head comes from storage so a pushed entry shows up one cycle later
    assign deq_if.walk = walk_mem[rd_ptr_q];
    assign deq_if.tag  = tag_mem[rd_ptr_q];
    assign deq_if.addr = addr_mem[rd_ptr_q];

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////

    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= occ_t'(`MRS_TXN_DEPTH))
        else $error("outstanding queue overflow");

    // Responder pops only a present head
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
        deq_if.strobe |-> !deq_if.stall)
        else $error("pop from an empty outstanding queue");

endmodule

`default_nettype wire

// ==== mrs_issuer.sv ====
// Input acceptance and req/gnt request machine of the memory read stage
// Tracks the in-flight count and pushes accepted transactions

`default_nettype none

`include "mrs_consts.svh"

module mrs_issuer (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    // Input stage
    input  wire logic          in_valid_i,
    output logic               in_ready_o,
    input  wire logic          in_walk_i,
    input  wire mrs_pkg::tag_t  in_tag_i,
    input  wire mrs_pkg::addr_t in_addr_i,
    // Memory request side
    output logic               mem_req_o,
    output mrs_pkg::addr_t     mem_addr_o,
    input  wire logic          mem_gnt_i,
    // One pulse per delivered result
    input  wire logic          retire_i,
    // Push side of the outstanding queue
    mrs_txn_if.writer          enq_if
);

    import mrs_pkg::*;

    issue_state_e state_q, state_d;
    occ_t         occ_q, occ_d;
    logic         room;
    logic         accept;

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////////////////////////////////////////

    // Queue entries plus the output register never exceed this count,
    // so a push always finds room in the queue
    assign room   = (occ_q < occ_t'(`MRS_TXN_DEPTH));
    assign accept = in_valid_i && in_ready_o;

    always_comb begin
        occ_d = occ_q;
        if (accept && !retire_i) begin
            occ_d = occ_q + occ_t'(1);
        end else if (!accept && retire_i) begin
            occ_d = occ_q - occ_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////////////////////

    // Address follows the input, stable while a request waits
    assign mem_addr_o = in_addr_i;

    always_comb begin
        state_d    = state_q;
        mem_req_o  = 1'b0;
        in_ready_o = 1'b0;
        case (state_q)
            ISSUE_IDLE: begin
                // Room is checked before any request goes out
                if (room) begin
                    if (in_walk_i) begin
                        mem_req_o  = in_valid_i;
                        // Gnt may already be high, accept in the same cycle
                        in_ready_o = mem_gnt_i;
                        if (in_valid_i && !mem_gnt_i) begin
                            state_d = ISSUE_WAIT_GNT;
                        end
                    end else begin
                        // No memory access, straight into the queue
                        in_ready_o = 1'b1;
                    end
                end
            end
            ISSUE_WAIT_GNT: begin
                // Hold the request, input is held stable meanwhile
                mem_req_o  = 1'b1;
                in_ready_o = mem_gnt_i;
                if (mem_gnt_i) begin
                    state_d = ISSUE_IDLE;
                end
            end
            default: begin
                state_d = ISSUE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ISSUE_IDLE;
            occ_q   <= '0;
        end else begin
            state_q <= state_d;
            occ_q   <= occ_d;
        end
    end

    // Every accepted transaction is queued, walking or not
    assign enq_if.strobe = accept;
    assign enq_if.walk   = in_walk_i;
    assign enq_if.tag    = in_tag_i;
    assign enq_if.addr   = in_addr_i;

    ////////////////////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////////////////////

    // Occupancy limit keeps the queue from being full at push time
    a_push_not_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        enq_if.strobe |-> !enq_if.stall)
        else $error("push into a full outstanding queue");

    // A raised request is held with the same address until granted
    a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("memory request dropped before grant");

endmodule

`default_nettype wire

// ==== mrs_txn_if.sv ====
// Transaction link between the stage blocks
// One strobe/stall pair plus the walk flag, tag and address

`default_nettype none

interface mrs_txn_if;

    import mrs_pkg::*;

    // Push or pop, depending on the side of the queue
    logic  strobe;
    // Full or empty, always driven by the queue
    logic  stall;

    // Transaction fields
    logic  walk;
    tag_t  tag;
    addr_t addr;

    // Producer pushing into the queue
    modport writer (
        output strobe,
        output walk,
        output tag,
        output addr,
        input  stall
    );

    // Queue write side, reports full
    modport fill (
        input  strobe,
        input  walk,
        input  tag,
        input  addr,
        output stall
    );

    // Queue read side, presents the head and reports empty
    modport drain (
        input  strobe,
        output walk,
        output tag,
        output addr,
        output stall
    );

    // Consumer popping from the queue
    modport reader (
        output strobe,
        input  walk,
        input  tag,
        input  addr,
        input  stall
    );

endinterface

`default_nettype wire

// ==== mrs_pkg.sv ====
// Vector typedefs and FSM state encodings of the memory read stage

`default_nettype none

`include "mrs_consts.svh"

package mrs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////////////////////////////////////////

    // Read address, or operand of a non-walking transaction
    typedef logic [`MRS_ADDR_W-1:0] addr_t;

    // Result word sent to the next stage
    typedef logic [`MRS_ADDR_W-1:0] data_t;

    // Transaction identifier
    typedef logic [`MRS_TAG_W-1:0] tag_t;

    // In-flight count, one extra bit so that the full depth fits
    typedef logic [$clog2(`MRS_TXN_DEPTH):0] occ_t;

    ////////////////////////////////////////////////////////////////////////////
    // FSM encodings
    ////////////////////////////////////////////////////////////////////////////

    // Request side of the issuer
    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_WAIT_GNT
    } issue_state_e;

    // Output result register
    typedef enum logic {
        OUT_EMPTY,
        OUT_FULL
    } out_state_e;

endpackage

`default_nettype wire

// ==== mrs_consts.svh ====
// Width, depth and occupancy constants for the memory read stage
// Shared by the package and the RTL modules

`ifndef MRS_CONSTS_SVH
`define MRS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Memory address, pass-through operand and read data all share this width
`define MRS_ADDR_W 32

// Transaction identifier returned with every result
`define MRS_TAG_W 4

////////////////////////////////////////////////////////////////////////////
// Queue sizing
////////////////////////////////////////////////////////////////////////////

// Limit on accepted but not yet retired transactions
// Also the depth of the outstanding queue and of the read-data queue
`define MRS_TXN_DEPTH 4

`endif
